//--- project.f
src/cart_pkg.sv
src/cart_header_scan.sv
src/region_select.sv
src/rom_write_gate.sv
src/cart_loader_top.sv
sim/cart_loader_checker.sv
sim/cart_loader_tb.sv

//--- Makefile
# Verilator build for the cartridge loader testbench

SIM_LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -f project.f \
		--top-module cart_loader_tb -o cart_loader_sim
	./obj_dir/cart_loader_sim | tee $(SIM_LOG)
	grep -q "all tests passed" $(SIM_LOG)

clean:
	rm -rf obj_dir $(SIM_LOG)

//--- sim/cart_loader_tb.sv
/*
 * Cartridge loader testbench
 * Random cartridge downloads against a reference model of the header
 * decode, ROM writes and region choice
 */
`timescale 1ns/100ps

module cart_loader_tb;

	localparam int CARTS      = 12;
	localparam int MAX_WORDS  = 288;
	localparam int TIMEOUT_NS = CARTS * MAX_WORDS * 8 * 4 + 2000;

	typedef struct packed {
		logic [23:0] addr;
		logic [15:0] data;
	} rom_write_t;

	logic                    clk_sys = 1'b0;
	logic                    RESET;
	logic                    dl_active;
	logic [7:0]              dl_index;
	cart_pkg::dl_word_t      dl;
	logic                    dl_wait;
	cart_pkg::auto_mode_t    auto_mode;
	cart_pkg::region_prio_t  region_prio;
	logic [23:0]             rom_addr;
	logic [15:0]             rom_data;
	logic                    rom_req;
	logic                    rom_ack;
	logic [24:0]             rom_size;
	cart_pkg::cart_info_t    cart_info;
	logic                    hdr_ready;
	cart_pkg::region_t       region_req;
	logic                    region_set;

	integer seed     = 32'h0d2c690a;
	integer ack_seed = 32'h0d2c690a ^ 32'h00005a5a;   // Responder stream
	logic [7:0] img [0:2*MAX_WORDS-1];                // Cartridge bytes
	logic req_level = 1'b0;                           // Expected rom_req level

	cart_loader_top #(.ADDR_W(25), .DATA_W(16)) cart_loader_top_inst (.*);

	bind cart_loader_top cart_loader_checker checker_inst (
		.clk_sys(clk_sys), .RESET(RESET), .dl_active(dl_active), .dl(dl),
		.dl_wait(dl_wait), .rom_req(rom_req), .rom_ack(rom_ack),
		.hdr_ready(hdr_ready), .region_set(region_set)
	);

	always #2 clk_sys = ~clk_sys;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("tests failed");
		$fatal(1);
	endtask

	////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////

	task automatic check_info(input cart_pkg::cart_info_t exp, input cart_pkg::cart_info_t got);
		if (exp !== got)
			fail_run($sformatf("ERROR cart_info exp %h got %h", exp, got));
	endtask

	task automatic check_region(input cart_pkg::region_t exp, input cart_pkg::region_t got);
		if (exp !== got)
			fail_run($sformatf("ERROR region_req exp %h got %h", exp, got));
	endtask

	task automatic check_write(input rom_write_t exp, input rom_write_t got);
		if (exp !== got)
			fail_run($sformatf("ERROR rom_addr/rom_data exp %h got %h", exp, got));
	endtask

	task automatic check_size(input logic [24:0] exp, input logic [24:0] got);
		if (exp !== got)
			fail_run($sformatf("ERROR rom_size exp %h got %h", exp, got));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic got);
		if (exp !== got)
			fail_run($sformatf("ERROR %s exp %h got %h", name, exp, got));
	endtask

	////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////

	function automatic cart_pkg::hdr_flags_t mark_flags(input logic [7:0] ch,
		input cart_pkg::hdr_flags_t cur);
		cart_pkg::hdr_flags_t f;
		logic [7:0]           v;
		f = cur;
		v = 8'd0;
		if (ch >= "1" && ch <= "9")
			v = ch - "0";
		else if (ch >= "A" && ch <= "F")
			v = ch - "A" + 8'd10;
		if (ch == "J")
			f.j = 1'b1;
		else if (ch == "U")
			f = '{j: 1'b0, u: 1'b1, e: 1'b0};
		else if (ch == "E")
			f = '{j: 1'b0, u: 1'b1, e: 1'b1};
		else if (v != 8'd0)
			f = '{j: v[0], u: v[2], e: v[3]};
		return f;
	endfunction

	function automatic cart_pkg::cart_info_t model_info();
		cart_pkg::cart_info_t m;
		logic [63:0]          code;
		m = '0;
		m.gun_delay = cart_pkg::GUN_DELAY_DEFAULT;
		m.hdr = mark_flags(img[12'h1F0], m.hdr);
		m.hdr = mark_flags(img[12'h1F1], m.hdr);
		m.hdr = mark_flags(img[12'h1F2], m.hdr);
		for (int i = 0; i < 8; i++)
			code[63-8*i -: 8] = img[12'h183 + i];   // Code starts at odd byte
		for (int i = 0; i < cart_pkg::QUIRK_N; i++)
			if (code == cart_pkg::QUIRK_TABLE[i].code)
				m.quirk = m.quirk | cart_pkg::QUIRK_TABLE[i].quirk;
		for (int i = 0; i < cart_pkg::GUN_N; i++) begin
			if (code == cart_pkg::GUN_TABLE[i].code) begin
				m.gun_type  = cart_pkg::GUN_TABLE[i].gun_type;
				m.gun_delay = cart_pkg::GUN_TABLE[i].gun_delay;
			end
		end
		return m;
	endfunction

	function automatic cart_pkg::region_t model_region(input cart_pkg::region_prio_t p,
		input cart_pkg::hdr_flags_t f);
		cart_pkg::region_t ord [3];
		case (p)
			cart_pkg::US_EU_JP: ord = '{cart_pkg::US, cart_pkg::EU, cart_pkg::JP};
			cart_pkg::EU_US_JP: ord = '{cart_pkg::EU, cart_pkg::US, cart_pkg::JP};
			cart_pkg::US_JP_EU: ord = '{cart_pkg::US, cart_pkg::JP, cart_pkg::EU};
			default:            ord = '{cart_pkg::JP, cart_pkg::US, cart_pkg::EU};
		endcase
		for (int i = 0; i < 3; i++) begin
			if ((ord[i] == cart_pkg::JP && f.j) || (ord[i] == cart_pkg::US && f.u) ||
				(ord[i] == cart_pkg::EU && f.e))
				return ord[i];
		end
		return ord[0];
	endfunction

	// One write beat and the checks on the edge that takes it
	task automatic send_beat(input logic [24:0] a, input logic [15:0] d);
		rom_write_t exp_w;
		req_level   = ~req_level;            // One toggle per beat
		exp_w.addr  = a[24:1];
		exp_w.data  = {d[7:0], d[15:8]};
		dl.wr   = 1'b1;
		dl.addr = a;
		dl.data = d;
		@(posedge clk_sys);
		#1;
		dl.wr = 1'b0;
		check_bit("rom_req", req_level, rom_req);
		check_bit("dl_wait", 1'b1, dl_wait);
		check_write(exp_w, {rom_addr, rom_data});
	endtask

	// Hold off until the memory answer clears dl_wait
	task automatic wait_ack();
		logic acked;
		acked = 1'b0;
		while (dl_wait) begin
			@(posedge clk_sys);
			acked = (rom_ack === req_level);   // Ack settles between edges
			#1;
			if (acked)
				check_bit("dl_wait", 1'b0, dl_wait);
		end
		if (!acked)
			fail_run("dl_wait fell before the memory acknowledge arrived");
		check_bit("rom_req", req_level, rom_req);
	endtask

	// Memory answers after 0 to 5 cycles
	initial begin : responder
		int d;
		forever begin
			@(posedge clk_sys);
			#1;
			if (!RESET && rom_req != rom_ack) begin
				d = $unsigned($random(ack_seed)) % 6;
				repeat (d) @(posedge clk_sys);
				#1 rom_ack = rom_req;
			end
		end
	end

	initial begin : watchdog
		#(TIMEOUT_NS);
		fail_run("Timeout: the downloads did not finish in the expected time");
	end

	////////////////////////////////////////////////////////////////////
	// Main stimulus
	////////////////////////////////////////////////////////////////////

	initial begin : stimulus
		string             marks;
		int                n_words;
		int                pick;
		logic [63:0]       code;
		logic              exp_set;
		cart_pkg::region_t exp_req;
		marks       = "JUE0123456789ABCDFXZ ";
		exp_req     = cart_pkg::JP;
		RESET       = 1'b1;
		dl_active   = 1'b0;
		dl_index    = 8'h00;
		dl          = '0;
		auto_mode   = cart_pkg::AUTO_HEADER;
		region_prio = cart_pkg::US_EU_JP;
		rom_ack     = 1'b0;
		repeat (3) @(posedge clk_sys);
		#1 RESET = 1'b0;

		for (int c = 0; c < CARTS; c++) begin
			n_words = 257 + ($unsigned($random(seed)) % 32);   // Always past 0x200
			for (int b = 0; b < 2*MAX_WORDS; b++)
				img[b] = 8'($random(seed));
			for (int b = 12'h1F0; b <= 12'h1F2; b++)
				img[b] = marks[$unsigned($random(seed)) % 21];
			pick = $unsigned($random(seed)) % 20;
			if (pick < cart_pkg::QUIRK_N)
				code = cart_pkg::QUIRK_TABLE[pick].code;
			else if (pick < cart_pkg::QUIRK_N + cart_pkg::GUN_N)
				code = cart_pkg::GUN_TABLE[pick - cart_pkg::QUIRK_N].code;
			else
				code = {$random(seed), $random(seed)};
			for (int i = 0; i < 8; i++)
				img[12'h183 + i] = code[63-8*i -: 8];
			auto_mode   = cart_pkg::auto_mode_t'(2'($random(seed)));
			region_prio = cart_pkg::region_prio_t'(2'($random(seed)));
			dl_index    = ($random(seed) & 1) ? 8'($random(seed)) : 8'h00;

			dl_active = 1'b1;
			@(posedge clk_sys);
			#1;
			for (int w = 0; w < n_words; w++) begin
				if (2*w <= 12'h200)
					check_bit("hdr_ready", 1'b0, hdr_ready);
				send_beat(25'(2*w), {img[2*w+1], img[2*w]});
				if (2*w == 12'h200) begin
					check_bit("hdr_ready", 1'b1, hdr_ready);
					exp_set = 1'b0;
					case (auto_mode)
						cart_pkg::AUTO_HEADER: begin
							exp_set = 1'b1;
							exp_req = model_region(region_prio, model_info().hdr);
						end
						cart_pkg::AUTO_FILE_EXT: begin
							exp_set = |dl_index;
							exp_req = cart_pkg::region_t'(dl_index[7:6]);
						end
						default: ;
					endcase
					// Region answer lands one edge after hdr_ready
					fork
						wait_ack();
						begin
							@(posedge clk_sys);
							#1;
							check_region(exp_req, region_req);
							check_bit("region_set", exp_set, region_set);
						end
					join
				end else begin
					wait_ack();
				end
			end
			check_info(model_info(), cart_info);

			// End of download
			dl_active = 1'b0;
			repeat (3) @(posedge clk_sys);
			#1;
			check_size(25'(2*(n_words-1)), rom_size);
			check_bit("hdr_ready", 1'b0, hdr_ready);
			check_bit("region_set", 1'b0, region_set);
		end

		$display("all tests passed");
		$finish;
	end

endmodule

//--- sim/cart_loader_checker.sv
/*
 * Cartridge loader protocol checker
 * Concurrent assertions on the ROM toggle handshake and region level
 */
`timescale 1ns/100ps

module cart_loader_checker (
	input  logic                clk_sys,
	input  logic                RESET,
	input  logic                dl_active,
	input  cart_pkg::dl_word_t  dl,
	input  logic                dl_wait,
	input  logic                rom_req,
	input  logic                rom_ack,
	input  logic                hdr_ready,
	input  logic                region_set
);

	// Producer must hold off while memory is busy
	no_beat_during_wait: assert property (@(posedge clk_sys) disable iff (RESET)
		(dl_active && dl.wr) |-> !dl_wait)
		else $error("write beat accepted while dl_wait was high");

	wait_while_outstanding: assert property (@(posedge clk_sys) disable iff (RESET)
		(rom_req != rom_ack) |-> dl_wait)
		else $error("request outstanding without dl_wait");

	// region_set trails hdr_ready by one cycle
	region_needs_header: assert property (@(posedge clk_sys) disable iff (RESET)
		(!hdr_ready && !$past(hdr_ready)) |-> !region_set)
		else $error("region_set high without a complete header");

endmodule

//--- src/cart_loader_top.sv
/*
 * Cartridge loader top level
 * Header scanner, ROM write gate and region selector on one download
 * stream
 */
`timescale 1ns/100ps

module cart_loader_top #(
	parameter int ADDR_W = 25,
	parameter int DATA_W = 16
) (
	input  logic                    clk_sys,
	input  logic                    RESET,

	// Download stream
	input  logic                    dl_active,
	input  logic [7:0]              dl_index,
	input  cart_pkg::dl_word_t      dl,
	output logic                    dl_wait,

	// Static settings
	input  cart_pkg::auto_mode_t    auto_mode,
	input  cart_pkg::region_prio_t  region_prio,

	// ROM memory port
	output logic [ADDR_W-2:0]       rom_addr,
	output logic [DATA_W-1:0]       rom_data,
	output logic                    rom_req,
	input  logic                    rom_ack,
	output logic [ADDR_W-1:0]       rom_size,

	// Cartridge info and region
	output cart_pkg::cart_info_t    cart_info,
	output logic                    hdr_ready,
	output cart_pkg::region_t       region_req,
	output logic                    region_set
);

	cart_header_scan #(
		.ADDR_W(ADDR_W),
		.DATA_W(DATA_W)
	) cart_header_scan_inst (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.dl_active (dl_active),
		.dl        (dl),
		.cart_info (cart_info),
		.hdr_ready (hdr_ready)
	);

	rom_write_gate #(
		.ADDR_W(ADDR_W),
		.DATA_W(DATA_W)
	) rom_write_gate_inst (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.dl_active (dl_active),
		.dl        (dl),
		.rom_ack   (rom_ack),
		.dl_wait   (dl_wait),
		.rom_req   (rom_req),
		.rom_addr  (rom_addr),
		.rom_data  (rom_data),
		.rom_size  (rom_size)
	);

	region_select region_select_inst (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.hdr_ready   (hdr_ready),
		.cart_info   (cart_info),
		.auto_mode   (auto_mode),
		.region_prio (region_prio),
		.dl_index    (dl_index),
		.region_req  (region_req),
		.region_set  (region_set)
	);

endmodule

//--- src/rom_write_gate.sv
/*
 * ROM write gate
 * Holds one download word in flight to memory on a toggle handshake
 * and records the ROM size at the end of the download
 */
`timescale 1ns/100ps

module rom_write_gate #(
	parameter int ADDR_W = 25,
	parameter int DATA_W = 16
) (
	input  logic                clk_sys,
	input  logic                RESET,
	input  logic                dl_active,
	input  cart_pkg::dl_word_t  dl,
	input  logic                rom_ack,
	output logic                dl_wait,
	output logic                rom_req,
	output logic [ADDR_W-2:0]   rom_addr,
	output logic [DATA_W-1:0]   rom_data,
	output logic [ADDR_W-1:0]   rom_size
);

	logic              beat;
	logic              dl_active_q;
	logic [ADDR_W-1:0] last_addr;

	assign beat = dl_active & dl.wr;

	// Word in flight, changes together with rom_req
	always_ff @(posedge clk_sys) begin
		if (beat) begin
			rom_addr  <= dl.addr[ADDR_W-1:1];   // Word address
			rom_data  <= {dl.data[DATA_W/2-1:0], dl.data[DATA_W-1:DATA_W/2]};
			last_addr <= dl.addr[ADDR_W-1:0];
		end
	end

	////////////////////////////////////////////////////////////////////
	// Toggle request and wait level
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_req     <= 1'b0;
			dl_wait     <= 1'b0;
			dl_active_q <= 1'b0;
			rom_size    <= '0;
		end else begin
			dl_active_q <= dl_active;

			if (beat) begin
				rom_req <= ~rom_req;
				dl_wait <= 1'b1;
			end else if (dl_wait && (rom_req == rom_ack)) begin
				dl_wait <= 1'b0;   // Memory has answered
			end

			if (dl_active_q & ~dl_active)
				rom_size <= last_addr;
		end
	end

endmodule

//--- src/region_select.sv
/*
 * Region request former
 * Picks a console region from the header flags or the download index
 * once the header is complete
 */
`timescale 1ns/100ps

module region_select (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    hdr_ready,
	input  cart_pkg::cart_info_t    cart_info,
	input  cart_pkg::auto_mode_t    auto_mode,
	input  cart_pkg::region_prio_t  region_prio,
	input  logic [7:0]              dl_index,
	output cart_pkg::region_t       region_req,
	output logic                    region_set
);

	logic hdr_ready_q;

	function automatic logic flag_of(
		input cart_pkg::region_t    r,
		input cart_pkg::hdr_flags_t f
	);
		case (r)
			cart_pkg::JP: return f.j;
			cart_pkg::US: return f.u;
			cart_pkg::EU: return f.e;
			default:      return 1'b0;
		endcase
	endfunction

	// First flagged region in the order, else the order's head
	function automatic cart_pkg::region_t pick_region(
		input cart_pkg::region_prio_t prio,
		input cart_pkg::hdr_flags_t   f
	);
		cart_pkg::region_t order [3];
		cart_pkg::region_t pick;
		case (prio)
			cart_pkg::US_EU_JP: order = '{cart_pkg::US, cart_pkg::EU, cart_pkg::JP};
			cart_pkg::EU_US_JP: order = '{cart_pkg::EU, cart_pkg::US, cart_pkg::JP};
			cart_pkg::US_JP_EU: order = '{cart_pkg::US, cart_pkg::JP, cart_pkg::EU};
			default:            order = '{cart_pkg::JP, cart_pkg::US, cart_pkg::EU};
		endcase
		pick = order[0];
		for (int i = 2; i >= 0; i--) begin
			if (flag_of(order[i], f))
				pick = order[i];
		end
		return pick;
	endfunction

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			hdr_ready_q <= 1'b0;
			region_req  <= cart_pkg::JP;
			region_set  <= 1'b0;
		end else begin
			hdr_ready_q <= hdr_ready;

			if (hdr_ready & ~hdr_ready_q) begin
				case (auto_mode)
					cart_pkg::AUTO_HEADER: begin
						region_set <= 1'b1;
						region_req <= pick_region(region_prio, cart_info.hdr);
					end
					cart_pkg::AUTO_FILE_EXT: begin
						region_set <= |dl_index;   // Index 0 means no extension hint
						region_req <= cart_pkg::region_t'(dl_index[7:6]);
					end
					default: ;                     // Auto region off
				endcase
			end

			if (~hdr_ready & hdr_ready_q)
				region_set <= 1'b0;
		end
	end

endmodule

//--- src/cart_header_scan.sv
/*
 * Cartridge header scanner
 * Watches download beats for region marks, the product code and the
 * end of the header, and publishes the decoded cartridge info
 */
`timescale 1ns/100ps

module cart_header_scan #(
	parameter int ADDR_W = 25,
	parameter int DATA_W = 16
) (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  logic                  dl_active,
	input  cart_pkg::dl_word_t    dl,
	output cart_pkg::cart_info_t  cart_info,
	output logic                  hdr_ready
);

	logic                  dl_active_q;
	logic                  beat;
	logic [ADDR_W-1:0]     addr;
	logic [7:0]            lo_byte;
	logic [7:0]            hi_byte;
	logic [63:0]           cart_id;
	cart_pkg::cart_info_t  info_q;
	logic                  hdr_ready_q;
	cart_pkg::quirk_t      id_quirk;
	logic                  id_gun_type;
	logic [7:0]            id_gun_delay;

	assign beat    = dl_active & dl.wr;
	assign addr    = dl.addr[ADDR_W-1:0];
	assign lo_byte = dl.data[7:0];         // Even byte of the file
	assign hi_byte = dl.data[DATA_W-1:DATA_W-8];

	// Region character to flags, unknown characters keep cur
	function automatic cart_pkg::hdr_flags_t decode_mark(
		input logic [7:0]           ch,
		input cart_pkg::hdr_flags_t cur
	);
		cart_pkg::hdr_flags_t res;
		logic [3:0]           val;
		logic                 is_hex;
		res    = cur;
		val    = 4'd0;
		is_hex = 1'b0;
		if (ch >= "1" && ch <= "9") begin
			is_hex = 1'b1;
			val    = ch[3:0];
		end else if (ch >= "A" && ch <= "F") begin
			is_hex = 1'b1;
			val    = ch[3:0] + 4'd9;
		end
		if (ch == "J")
			res.j = 1'b1;
		else if (ch == "U")
			res = 3'b010;
		else if (ch == "E")
			res = 3'b011;           // Europe implies US too
		else if (is_hex) begin
			res.j = val[0];
			res.u = val[2];
			res.e = val[3];
		end
		return res;
	endfunction

	////////////////////////////////////////////////////////////////////
	// Product code table lookup
	////////////////////////////////////////////////////////////////////

	always_comb begin
		id_quirk     = '0;
		id_gun_type  = 1'b0;
		id_gun_delay = cart_pkg::GUN_DELAY_DEFAULT;
		for (int i = 0; i < cart_pkg::QUIRK_N; i++) begin
			if (cart_id == cart_pkg::QUIRK_TABLE[i].code)
				id_quirk = id_quirk | cart_pkg::QUIRK_TABLE[i].quirk;
		end
		for (int i = 0; i < cart_pkg::GUN_N; i++) begin
			if (cart_id == cart_pkg::GUN_TABLE[i].code) begin
				id_gun_type  = cart_pkg::GUN_TABLE[i].gun_type;
				id_gun_delay = cart_pkg::GUN_TABLE[i].gun_delay;
			end
		end
	end

	// Code bytes stored in file order, first character on top
	always_ff @(posedge clk_sys) begin
		if (beat) begin
			if (addr == ADDR_W'(cart_pkg::ADDR_ID_FIRST))
				cart_id[63:56] <= hi_byte;
			if (addr == ADDR_W'(cart_pkg::ADDR_ID_FIRST + 25'd2))
				cart_id[55:40] <= {lo_byte, hi_byte};
			if (addr == ADDR_W'(cart_pkg::ADDR_ID_FIRST + 25'd4))
				cart_id[39:24] <= {lo_byte, hi_byte};
			if (addr == ADDR_W'(cart_pkg::ADDR_ID_FIRST + 25'd6))
				cart_id[23:8] <= {lo_byte, hi_byte};
			if (addr == ADDR_W'(cart_pkg::ADDR_ID_FIRST + 25'd8))
				cart_id[7:0] <= lo_byte;   // Last character
		end
	end

	////////////////////////////////////////////////////////////////////
	// Flags, quirks and header-complete level
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_active_q         <= 1'b0;
			info_q.hdr          <= '0;
			info_q.quirk        <= '0;
			info_q.gun_type     <= 1'b0;
			info_q.gun_delay    <= cart_pkg::GUN_DELAY_DEFAULT;
			hdr_ready_q         <= 1'b0;
		end else begin
			dl_active_q <= dl_active;

			// New download starts from a blank header
			if (dl_active & ~dl_active_q) begin
				info_q.hdr   <= '0;
				info_q.quirk <= '0;
			end
			if (~dl_active & dl_active_q)
				hdr_ready_q <= 1'b0;

			if (beat) begin
				if (addr == ADDR_W'(cart_pkg::ADDR_REGION_LO))
					info_q.hdr <= decode_mark(hi_byte, decode_mark(lo_byte, info_q.hdr));
				else if (addr == ADDR_W'(cart_pkg::ADDR_REGION_HI))
					info_q.hdr <= decode_mark(lo_byte, info_q.hdr);

				if (addr == ADDR_W'(cart_pkg::ADDR_ID_CHECK)) begin
					info_q.quirk     <= info_q.quirk | id_quirk;
					info_q.gun_type  <= id_gun_type;
					info_q.gun_delay <= id_gun_delay;
				end

				if (addr == ADDR_W'(cart_pkg::ADDR_HDR_DONE))
					hdr_ready_q <= 1'b1;
			end
		end
	end

	assign cart_info = info_q;
	assign hdr_ready = hdr_ready_q;

endmodule

//--- src/cart_pkg.sv
/*
 * Cartridge loader shared types
 * Download beat, region and quirk encodings, header addresses and
 * the product code table used by the header scanner
 */
package cart_pkg;

	////////////////////////////////////////////////////////////////////
	// Download and info records
	////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic        wr;    // Write strobe
		logic [24:0] addr;  // Byte address
		logic [15:0] data;
	} dl_word_t;

	typedef enum logic [1:0] {JP = 2'd0, US = 2'd1, EU = 2'd2} region_t;

	typedef enum logic [1:0] {US_EU_JP, EU_US_JP, US_JP_EU, JP_US_EU} region_prio_t;

	// Encoding 3 acts as AUTO_OFF
	typedef enum logic [1:0] {AUTO_HEADER, AUTO_FILE_EXT, AUTO_OFF} auto_mode_t;

	typedef struct packed {
		logic j;
		logic u;
		logic e;
	} hdr_flags_t;

	typedef struct packed {
		logic sram;
		logic eeprom;
		logic svp;
		logic fmbusy;
	} quirk_t;

	typedef struct packed {
		hdr_flags_t  hdr;
		quirk_t      quirk;
		logic        gun_type;
		logic [7:0]  gun_delay;  // Light-gun sensor delay
	} cart_info_t;

	////////////////////////////////////////////////////////////////////
	// Header map
	////////////////////////////////////////////////////////////////////

	localparam logic [24:0] ADDR_REGION_LO = 25'h1F0;
	localparam logic [24:0] ADDR_REGION_HI = 25'h1F2;
	localparam logic [24:0] ADDR_ID_FIRST  = 25'h182;
	localparam logic [24:0] ADDR_ID_CHECK  = 25'h18C;
	localparam logic [24:0] ADDR_HDR_DONE  = 25'h200;

	localparam logic [7:0] GUN_DELAY_DEFAULT = 8'd44;

	// Product codes needing special handling
	typedef struct packed {
		logic [63:0] code;
		quirk_t      quirk;
	} quirk_entry_t;

	typedef struct packed {
		logic [63:0] code;
		logic        gun_type;
		logic [7:0]  gun_delay;
	} gun_entry_t;

	localparam int QUIRK_N = 10;
	localparam quirk_entry_t QUIRK_TABLE [QUIRK_N] = '{
		'{code: "T-081276", quirk: 4'b1000},
		'{code: "T-81406 ", quirk: 4'b1000},
		'{code: "T-081586", quirk: 4'b1000},
		'{code: "MK-1215 ", quirk: 4'b0100},
		'{code: "G-4060  ", quirk: 4'b0100},
		'{code: "T-12046 ", quirk: 4'b0100},
		'{code: "MK-1229 ", quirk: 4'b0010},
		'{code: "G-7001  ", quirk: 4'b0010},
		'{code: "T-35036 ", quirk: 4'b0001},
		'{code: "T-25073 ", quirk: 4'b0001}
	};

	localparam int GUN_N = 5;
	localparam gun_entry_t GUN_TABLE [GUN_N] = '{
		'{code: "MK-1533 ", gun_type: 1'b0, gun_delay: 8'd100},
		'{code: "T-95096-", gun_type: 1'b1, gun_delay: 8'd52},
		'{code: "T-95136-", gun_type: 1'b1, gun_delay: 8'd30},
		'{code: "MK-1658 ", gun_type: 1'b0, gun_delay: 8'd120},
		'{code: "T-081156", gun_type: 1'b0, gun_delay: 8'd126}
	};

endpackage
